/* include/bpu_cfg.svh */
/*
 * Branch prediction unit configuration
 * Table sizes, return stack depth and the fetch address after reset
 */

`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// BTB set index bits per bank
// 64 sets
`define BPU_BTB_ADDR_WIDTH 6

// Index bits of one pattern counter bank
// 128 counters per bank
`define BPU_PHT_ADDR_WIDTH 7

// Return stack entries, power of two
`define BPU_RAS_DEPTH 8
`define BPU_RAS_PTR_WIDTH $clog2(`BPU_RAS_DEPTH)

// First fetch address out of reset
`define BPU_RESET_PC 32'h1c00_0000

`endif

/* hw/bpu_pkg.sv */
/*
 * Branch prediction types
 * Branch kind encoding and the 2-bit pattern counter with its update rule
 */

package bpu_pkg;

  // Branch kind as stored in the BTB
  typedef enum logic [1:0] {
    BR_NONE   = 2'b00,
    BR_COND   = 2'b01,
    BR_CALL   = 2'b10,
    BR_RETURN = 2'b11
  } br_type_e;

  // Saturating counter
  // Upper bit set predicts taken
  typedef logic [1:0] counter_t;

  // Weakly not taken
  localparam counter_t CNT_RESET = 2'b01;

  // One step towards the outcome, clamped to 0..3
  function automatic counter_t cnt_update(counter_t cnt, logic taken);
    counter_t res;
    res = cnt;
    if (taken && cnt != 2'b11) begin
      res = cnt + 2'd1;
    end else if (!taken && cnt != 2'b00) begin
      res = cnt - 2'd1;
    end
    return res;
  endfunction

endpackage

/* hw/pattern_history_table.sv */
/*
 * Pattern history table bank
 * 2-bit saturating counters, one cycle read, training write at the edge
 */

`timescale 1ns/100ps

module pattern_history_table #(
  parameter int ADDR_WIDTH = 7
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Training port
  input  logic                  we_i,
  input  logic                  taken_i,
  input  bpu_pkg::counter_t     counter_i,
  // Index of the packet being read and of the trained branch
  input  logic [ADDR_WIDTH-1:0] rindex_i,
  input  logic [ADDR_WIDTH-1:0] windex_i,
  // Counter of the read index, one cycle later
  output bpu_pkg::counter_t     counter_o
);

  localparam int ENTRIES = 1 << ADDR_WIDTH;

  bpu_pkg::counter_t table_q [ENTRIES];

  // ==================================================
  // Counter array
  // ==================================================

  // Update is based on the counter the back end saw at prediction time
  // so a stale read never moves the counter twice
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        table_q[i] <= bpu_pkg::CNT_RESET;
      end
    end else if (we_i) begin
      table_q[windex_i] <= bpu_pkg::cnt_update(counter_i, taken_i);
    end
  end

  // ==================================================
  // Registered read
  // ==================================================

  // Same-cycle write is not forwarded
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counter_o <= bpu_pkg::CNT_RESET;
    end else begin
      counter_o <= table_q[rindex_i];
    end
  end

endmodule

/* hw/branch_target_buffer.sv */
/*
 * Branch target buffer
 * Direct mapped and tagged, one bank per fetch slot
 * Read is registered, a miss reads back as no branch
 */

`timescale 1ns/100ps

module branch_target_buffer #(
  parameter int ADDR_WIDTH = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  // Word address of the packet to look up
  input  logic [31:2]       rpc_i,
  // Training port
  input  logic              we_i,
  input  logic [31:2]       wpc_i,
  input  logic [31:2]       bta_i,
  input  bpu_pkg::br_type_e br_type_i,
  // Per slot result, one cycle after rpc_i
  output logic [31:2]       bta_o [2],
  output bpu_pkg::br_type_e br_type_o [2]
);

  localparam int SETS      = 1 << ADDR_WIDTH;
  localparam int TAG_WIDTH = 29 - ADDR_WIDTH;

  // Entry storage
  logic [SETS-1:0]      valid_q [2];
  logic [TAG_WIDTH-1:0] tag_q   [2][SETS];
  bpu_pkg::br_type_e    type_q  [2][SETS];
  logic [31:2]          bta_q   [2][SETS];

  // Read side registers
  logic                 rd_valid_q [2];
  logic [TAG_WIDTH-1:0] rd_tag_q   [2];
  bpu_pkg::br_type_e    rd_type_q  [2];
  logic [31:2]          rd_bta_q   [2];
  logic [TAG_WIDTH-1:0] rd_ptag_q;

  // Address split
  // Bit 2 picks the slot, the set index sits right above it
  logic [ADDR_WIDTH-1:0] ridx;
  logic [ADDR_WIDTH-1:0] widx;
  logic [TAG_WIDTH-1:0]  rtag;
  logic [TAG_WIDTH-1:0]  wtag;
  logic                  wbank;

  assign ridx  = rpc_i[ADDR_WIDTH+2:3];
  assign rtag  = rpc_i[31:ADDR_WIDTH+3];
  assign widx  = wpc_i[ADDR_WIDTH+2:3];
  assign wtag  = wpc_i[31:ADDR_WIDTH+3];
  assign wbank = wpc_i[2];

  // ==================================================
  // Training write
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        valid_q[b] <= '0;
      end
    end else if (we_i) begin
      valid_q[wbank][widx] <= 1'b1;
    end
  end

  // Payload of the entry
  always_ff @(posedge clk) begin
    if (we_i) begin
      tag_q[wbank][widx]  <= wtag;
      type_q[wbank][widx] <= br_type_i;
      bta_q[wbank][widx]  <= bta_i;
    end
  end

  // ==================================================
  // Lookup
  // ==================================================

  // Both banks are read at the same set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        rd_valid_q[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        rd_valid_q[b] <= valid_q[b][ridx];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_ptag_q <= rtag;
    for (int b = 0; b < 2; b++) begin
      rd_tag_q[b]  <= tag_q[b][ridx];
      rd_type_q[b] <= type_q[b][ridx];
      rd_bta_q[b]  <= bta_q[b][ridx];
    end
  end

  // Tag compare after the register
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bta_o[b] = rd_bta_q[b];
      if (rd_valid_q[b] && rd_tag_q[b] == rd_ptag_q) begin
        br_type_o[b] = rd_type_q[b];
      end else begin
        br_type_o[b] = bpu_pkg::BR_NONE;
      end
    end
  end

endmodule

/* hw/return_address_stack.sv */
/*
 * Return address stack
 * Circular buffer of word addresses, oldest entry lost on overflow
 * Pointer restore from the back end wins over push and pop
 */

`timescale 1ns/100ps

module return_address_stack #(
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_i,
  input  logic                     pop_i,
  input  logic                     restore_i,
  // Return point of a predicted call
  input  logic [31:2]              push_addr_i,
  // Pointer captured with the mispredicted packet
  input  logic [$clog2(DEPTH)-1:0] restore_ptr_i,
  // Current top, combinational
  output logic [31:2]              top_o,
  output logic [$clog2(DEPTH)-1:0] ptr_o
);

  localparam int PTR_WIDTH = $clog2(DEPTH);

  logic [31:2]          stack_q [DEPTH];
  logic [PTR_WIDTH-1:0] ptr_q;
  logic [PTR_WIDTH-1:0] ptr_inc;
  logic [PTR_WIDTH-1:0] ptr_dec;

  // Pointer arithmetic wraps at DEPTH
  assign ptr_inc = ptr_q + 1'b1;
  assign ptr_dec = ptr_q - 1'b1;

  // ==================================================
  // Stack and pointer
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        stack_q[i] <= '0;
      end
    end else if (restore_i) begin
      // Entries above the restored pointer stay as they are
      ptr_q <= restore_ptr_i;
    end else if (push_i) begin
      ptr_q            <= ptr_inc;
      stack_q[ptr_inc] <= push_addr_i;
    end else if (pop_i) begin
      ptr_q <= ptr_dec;
    end
  end

  // Top of stack
  assign top_o = stack_q[ptr_q];
  assign ptr_o = ptr_q;

endmodule

/* hw/branch_prediction_unit.sv */
/*
 * Branch prediction unit
 * Fetch PC register and next PC select for a two-wide fetch packet
 * One prediction per packet from BTB, two PHT banks and the RAS
 */

`timescale 1ns/100ps

`include "bpu_cfg.svh"

module branch_prediction_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  // Fetch stage advance
  input  logic                          next_i,
  // Back end redirect, one cycle pulse
  input  logic                          redirect_i,
  input  logic [31:0]                   redirect_target_i,
  // Training from the back end
  input  logic                          upd_btb_i,
  input  logic                          upd_pht_i,
  input  logic                          upd_taken_i,
  input  logic [31:0]                   upd_pc_i,
  input  logic [31:0]                   upd_target_i,
  input  bpu_pkg::br_type_e             upd_br_type_i,
  input  bpu_pkg::counter_t             upd_counter_i,
  input  logic                          ras_restore_i,
  input  logic [`BPU_RAS_PTR_WIDTH-1:0] ras_restore_ptr_i,
  // Packet out to fetch
  output logic [31:0]                   pc_o,
  output logic [31:0]                   npc_o,
  output logic [1:0]                    valid_o,
  // Prediction metadata, returned later with the update
  output logic                          pred_taken_o,
  output logic                          pred_idx_o,
  output bpu_pkg::br_type_e             pred_type_o,
  output bpu_pkg::counter_t             pred_counter_o,
  output logic [`BPU_RAS_PTR_WIDTH-1:0] ras_ptr_o
);

  // Fetch PC and its successors
  logic [31:0] pc_q;
  logic [31:0] npc;
  logic [31:0] ppc;

  // Table outputs, indexed by slot
  bpu_pkg::br_type_e btb_type [2];
  logic [31:2]       btb_bta  [2];
  bpu_pkg::counter_t pht_cnt  [2];
  logic [1:0]        pht_we;

  // Stack side
  logic [31:2]                   ras_top;
  logic [`BPU_RAS_PTR_WIDTH-1:0] ras_ptr;
  logic                          ras_push;
  logic                          ras_pop;
  logic [31:2]                   ret_addr;

  // Prediction combine
  logic [1:0]        slot_taken;
  logic              slot0_taken;
  logic              pred_taken;
  logic              pred_idx;
  bpu_pkg::br_type_e pred_type;

  // ==================================================
  // Fetch PC
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `BPU_RESET_PC;
    end else begin
      pc_q <= npc;
    end
  end

  // Redirect first, then advance, else hold
  assign npc = redirect_i ? redirect_target_i :
               next_i     ? ppc :
                            pc_q;

  // ==================================================
  // Prediction tables
  // ==================================================

  // Tables are read with npc so their data lines up with pc_q
  branch_target_buffer #(
    .ADDR_WIDTH (`BPU_BTB_ADDR_WIDTH)
  ) u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .rpc_i     (npc[31:2]),
    .we_i      (upd_btb_i),
    .wpc_i     (upd_pc_i[31:2]),
    .bta_i     (upd_target_i[31:2]),
    .br_type_i (upd_br_type_i),
    .bta_o     (btb_bta),
    .br_type_o (btb_type)
  );

  // Counter bank chosen by the slot bit of the trained branch
  assign pht_we[0] = upd_pht_i & ~upd_pc_i[2];
  assign pht_we[1] = upd_pht_i &  upd_pc_i[2];

  pattern_history_table #(
    .ADDR_WIDTH (`BPU_PHT_ADDR_WIDTH)
  ) u_pht_bank0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .we_i      (pht_we[0]),
    .taken_i   (upd_taken_i),
    .counter_i (upd_counter_i),
    .rindex_i  (npc[`BPU_PHT_ADDR_WIDTH+2:3]),
    .windex_i  (upd_pc_i[`BPU_PHT_ADDR_WIDTH+2:3]),
    .counter_o (pht_cnt[0])
  );

  pattern_history_table #(
    .ADDR_WIDTH (`BPU_PHT_ADDR_WIDTH)
  ) u_pht_bank1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .we_i      (pht_we[1]),
    .taken_i   (upd_taken_i),
    .counter_i (upd_counter_i),
    .rindex_i  (npc[`BPU_PHT_ADDR_WIDTH+2:3]),
    .windex_i  (upd_pc_i[`BPU_PHT_ADDR_WIDTH+2:3]),
    .counter_o (pht_cnt[1])
  );

  // Push and pop only when the packet is actually consumed
  assign ras_push = next_i & pred_taken & (pred_type == bpu_pkg::BR_CALL);
  assign ras_pop  = next_i & pred_taken & (pred_type == bpu_pkg::BR_RETURN);

  // Word after the chosen slot
  assign ret_addr = {pc_q[31:3], pred_idx} + 30'd1;

  return_address_stack #(
    .DEPTH (`BPU_RAS_DEPTH)
  ) u_ras (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (ras_push),
    .pop_i         (ras_pop),
    .restore_i     (ras_restore_i),
    .push_addr_i   (ret_addr),
    .restore_ptr_i (ras_restore_ptr_i),
    .top_o         (ras_top),
    .ptr_o         (ras_ptr)
  );

  // ==================================================
  // Prediction combine
  // ==================================================

  // Calls and returns always jump, conditionals follow their counter
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      case (btb_type[s])
        bpu_pkg::BR_CALL,
        bpu_pkg::BR_RETURN: slot_taken[s] = 1'b1;
        bpu_pkg::BR_COND:   slot_taken[s] = pht_cnt[s][1];
        default:            slot_taken[s] = 1'b0;
      endcase
    end
  end

  // Slot 0 is skipped when the packet is entered at offset 4
  assign slot0_taken = slot_taken[0] & ~pc_q[2];
  assign pred_idx    = ~slot0_taken;
  assign pred_taken  = slot0_taken | slot_taken[1];
  assign pred_type   = btb_type[pred_idx];

  // Stack top for returns, BTB target if taken, else next aligned packet
  assign ppc = (pred_type == bpu_pkg::BR_RETURN) ? {ras_top, 2'b00} :
               pred_taken                        ? {btb_bta[pred_idx], 2'b00} :
                                                   {pc_q[31:3] + 29'd1, 3'b000};

  // ==================================================
  // Outputs
  // ==================================================

  assign pc_o  = pc_q;
  assign npc_o = npc;

  // Slot 1 dies behind a taken slot 0
  assign valid_o[0] = next_i & ~pc_q[2];
  assign valid_o[1] = next_i & ~slot0_taken;

  assign pred_taken_o   = pred_taken;
  assign pred_idx_o     = pred_idx;
  assign pred_type_o    = pred_type;
  assign pred_counter_o = pht_cnt[pred_idx];
  assign ras_ptr_o      = ras_ptr;

endmodule

/* verif/tb_bpu.sv */
/*
 * Testbench for the branch prediction unit
 * Reference model of tables, stack and fetch PC, compared on every edge
 */

`timescale 1ns/100ps

`include "bpu_cfg.svh"

module tb_bpu;

  localparam int BTB_SETS   = 1 << `BPU_BTB_ADDR_WIDTH;
  localparam int PHT_SIZE   = 1 << `BPU_PHT_ADDR_WIDTH;
  localparam int PTR_W      = $clog2(`BPU_RAS_DEPTH);
  localparam int MAX_CYCLES = 4000;
  localparam int POOL_SIZE  = 12;

  // Expected outputs of one cycle
  typedef struct packed {
    logic [31:0]       npc;
    logic [1:0]        valid;
    logic              taken;
    logic              idx;
    bpu_pkg::br_type_e btype;
    bpu_pkg::counter_t cnt;
  } pred_t;

  // DUT inputs
  logic              clk;
  logic              rst_n;
  logic              next_i;
  logic              redirect_i;
  logic [31:0]       redirect_target_i;
  logic              upd_btb_i;
  logic              upd_pht_i;
  logic              upd_taken_i;
  logic [31:0]       upd_pc_i;
  logic [31:0]       upd_target_i;
  bpu_pkg::br_type_e upd_br_type_i;
  bpu_pkg::counter_t upd_counter_i;
  logic              ras_restore_i;
  logic [PTR_W-1:0]  ras_restore_ptr_i;

  // DUT outputs
  logic [31:0]       pc_o;
  logic [31:0]       npc_o;
  logic [1:0]        valid_o;
  logic              pred_taken_o;
  logic              pred_idx_o;
  bpu_pkg::br_type_e pred_type_o;
  bpu_pkg::counter_t pred_counter_o;
  logic [PTR_W-1:0]  ras_ptr_o;

  // Reference model state
  logic [31:0]       m_pc;
  bpu_pkg::br_type_e m_rd_type [2];
  logic [31:2]       m_rd_bta  [2];
  bpu_pkg::counter_t m_rd_cnt  [2];
  logic              m_btb_vld  [2][BTB_SETS];
  logic [31:0]       m_btb_tag  [2][BTB_SETS];
  bpu_pkg::br_type_e m_btb_type [2][BTB_SETS];
  logic [31:2]       m_btb_bta  [2][BTB_SETS];
  bpu_pkg::counter_t m_pht      [2][PHT_SIZE];
  logic [31:2]       m_ras      [`BPU_RAS_DEPTH];
  logic [PTR_W-1:0]  m_ras_ptr;

  pred_t expected;
  int    cycles;

  branch_prediction_unit dut (.*);

  // ==================================================
  // Clock, reset and timeout
  // ==================================================

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "run aborted by cycle limit");
    end
  end

  // ==================================================
  // Reference model
  // ==================================================

  function automatic int btb_set(logic [31:0] pc);
    return (pc >> 3) % BTB_SETS;
  endfunction

  function automatic logic [31:0] btb_tag(logic [31:0] pc);
    return pc >> (`BPU_BTB_ADDR_WIDTH + 3);
  endfunction

  function automatic int pht_index(logic [31:0] pc);
    return (pc >> 3) % PHT_SIZE;
  endfunction

  // Step towards the outcome and clamp at both ends
  function automatic bpu_pkg::counter_t saturate(bpu_pkg::counter_t cnt, logic taken);
    bpu_pkg::counter_t res;
    res = cnt;
    if (taken && cnt != 2'd3) begin
      res = cnt + 2'd1;
    end else if (!taken && cnt != 2'd0) begin
      res = cnt - 2'd1;
    end
    return res;
  endfunction

  // Outputs for the current model PC and table read
  function automatic pred_t predict(logic nxt, logic redir, logic [31:0] target);
    pred_t       p;
    logic [1:0]  slot_tk;
    logic        s0;
    logic [31:0] ppc;
    for (int s = 0; s < 2; s++) begin
      slot_tk[s] = (m_rd_type[s] == bpu_pkg::BR_CALL) ||
                   (m_rd_type[s] == bpu_pkg::BR_RETURN) ||
                   (m_rd_type[s] == bpu_pkg::BR_COND && m_rd_cnt[s][1]);
    end
    // Slot 0 ignored when entering at offset 4
    s0      = slot_tk[0] && !m_pc[2];
    p.idx   = !s0;
    p.taken = s0 || slot_tk[1];
    p.btype = m_rd_type[p.idx];
    p.cnt   = m_rd_cnt[p.idx];
    p.valid = {nxt && !s0, nxt && !m_pc[2]};
    if (p.btype == bpu_pkg::BR_RETURN) begin
      ppc = {m_ras[m_ras_ptr], 2'b00};
    end else if (p.taken) begin
      ppc = {m_rd_bta[p.idx], 2'b00};
    end else begin
      ppc = (m_pc & ~32'h7) + 32'd8;
    end
    if (redir) begin
      p.npc = target;
    end else if (nxt) begin
      p.npc = ppc;
    end else begin
      p.npc = m_pc;
    end
    return p;
  endfunction

  task automatic reset_model();
    m_pc      = `BPU_RESET_PC;
    m_ras_ptr = '0;
    for (int s = 0; s < 2; s++) begin
      m_rd_type[s] = bpu_pkg::BR_NONE;
      m_rd_cnt[s]  = 2'b01;
      for (int i = 0; i < BTB_SETS; i++) begin
        m_btb_vld[s][i] = 1'b0;
      end
      for (int i = 0; i < PHT_SIZE; i++) begin
        m_pht[s][i] = 2'b01;
      end
    end
    for (int i = 0; i < `BPU_RAS_DEPTH; i++) begin
      m_ras[i] = '0;
    end
  endtask

  // One clock edge does the table read of npc, then training, then stack
  task automatic advance_model(pred_t e);
    int          idx;
    int          bank;
    logic [31:2] ret;
    idx = btb_set(e.npc);
    for (int s = 0; s < 2; s++) begin
      if (m_btb_vld[s][idx] && m_btb_tag[s][idx] == btb_tag(e.npc)) begin
        m_rd_type[s] = m_btb_type[s][idx];
      end else begin
        m_rd_type[s] = bpu_pkg::BR_NONE;
      end
      m_rd_bta[s] = m_btb_bta[s][idx];
      m_rd_cnt[s] = m_pht[s][pht_index(e.npc)];
    end
    bank = upd_pc_i[2];
    if (upd_btb_i) begin
      idx                   = btb_set(upd_pc_i);
      m_btb_vld[bank][idx]  = 1'b1;
      m_btb_tag[bank][idx]  = btb_tag(upd_pc_i);
      m_btb_type[bank][idx] = upd_br_type_i;
      m_btb_bta[bank][idx]  = upd_target_i[31:2];
    end
    if (upd_pht_i) begin
      m_pht[bank][pht_index(upd_pc_i)] = saturate(upd_counter_i, upd_taken_i);
    end
    // Return point is the word after the chosen slot
    ret = {m_pc[31:3], e.idx} + 30'd1;
    if (ras_restore_i) begin
      m_ras_ptr = ras_restore_ptr_i;
    end else if (next_i && e.taken && e.btype == bpu_pkg::BR_CALL) begin
      m_ras_ptr        = m_ras_ptr + 1'b1;
      m_ras[m_ras_ptr] = ret;
    end else if (next_i && e.taken && e.btype == bpu_pkg::BR_RETURN) begin
      m_ras_ptr = m_ras_ptr - 1'b1;
    end
    m_pc = e.npc;
  endtask

  // ==================================================
  // Compare
  // ==================================================

  task automatic report_mismatch(string field, logic [31:0] got, logic [31:0] want);
    $display("ERROR %0t ns: %s is %h, expected %h", $time, field, got, want);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_value(string field, logic [31:0] got, logic [31:0] want);
    assert (got === want) else report_mismatch(field, got, want);
  endtask

  // Outputs sampled before the edge updates the DUT registers
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      expected = predict(next_i, redirect_i, redirect_target_i);
      assert (pc_o === m_pc) else report_mismatch("pc_o", pc_o, m_pc);
      assert (npc_o === expected.npc) else report_mismatch("npc_o", npc_o, expected.npc);
      assert (valid_o === expected.valid)
        else report_mismatch("valid_o", valid_o, expected.valid);
      assert (pred_taken_o === expected.taken)
        else report_mismatch("pred_taken_o", pred_taken_o, expected.taken);
      assert (pred_idx_o === expected.idx)
        else report_mismatch("pred_idx_o", pred_idx_o, expected.idx);
      assert (pred_type_o === expected.btype)
        else report_mismatch("pred_type_o", pred_type_o, expected.btype);
      assert (pred_counter_o === expected.cnt)
        else report_mismatch("pred_counter_o", pred_counter_o, expected.cnt);
      assert (ras_ptr_o === m_ras_ptr) else report_mismatch("ras_ptr_o", ras_ptr_o, m_ras_ptr);
      advance_model(expected);
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  task automatic fetch(int n);
    @(negedge clk);
    next_i = 1'b1;
    repeat (n) @(negedge clk);
    next_i = 1'b0;
  endtask

  task automatic redirect(logic [31:0] target);
    @(negedge clk);
    next_i            = 1'b0;
    redirect_i        = 1'b1;
    redirect_target_i = target;
    @(negedge clk);
    redirect_i = 1'b0;
  endtask

  task automatic train_btb(logic [31:0] pc, logic [31:0] target, bpu_pkg::br_type_e btype);
    @(negedge clk);
    upd_btb_i     = 1'b1;
    upd_pc_i      = pc;
    upd_target_i  = target;
    upd_br_type_i = btype;
    @(negedge clk);
    upd_btb_i = 1'b0;
  endtask

  task automatic train_pht(logic [31:0] pc, bpu_pkg::counter_t cnt, logic taken);
    @(negedge clk);
    upd_pht_i     = 1'b1;
    upd_pc_i      = pc;
    upd_counter_i = cnt;
    upd_taken_i   = taken;
    @(negedge clk);
    upd_pht_i = 1'b0;
  endtask

  task automatic restore(logic [PTR_W-1:0] ptr, logic nxt);
    @(negedge clk);
    ras_restore_i     = 1'b1;
    ras_restore_ptr_i = ptr;
    next_i            = nxt;
    @(negedge clk);
    ras_restore_i = 1'b0;
    next_i        = 1'b0;
  endtask

  task automatic step_and_check(logic [31:0] want_pc, logic [PTR_W-1:0] want_ptr);
    fetch(1);
    check_value("pc_o", pc_o, want_pc);
    check_value("ras_ptr_o", ras_ptr_o, want_ptr);
  endtask

  initial begin
    logic [31:0]       pool [POOL_SIZE];
    logic [31:0]       slot_pc;
    bpu_pkg::counter_t cnt;
    void'($urandom(10737));
    cycles            = 0;
    rst_n             = 1'b0;
    next_i            = 1'b0;
    redirect_i        = 1'b0;
    redirect_target_i = '0;
    upd_btb_i         = 1'b0;
    upd_pht_i         = 1'b0;
    upd_taken_i       = 1'b0;
    upd_pc_i          = '0;
    upd_target_i      = '0;
    upd_br_type_i     = bpu_pkg::BR_NONE;
    upd_counter_i     = 2'b01;
    ras_restore_i     = 1'b0;
    ras_restore_ptr_i = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Sequential fetch with empty tables
    @(negedge clk);
    check_value("pc_o", pc_o, `BPU_RESET_PC);
    check_value("valid_o", valid_o, 2'b00);
    fetch(20);
    check_value("pc_o", pc_o, `BPU_RESET_PC + 32'd160);

    // Entry at offset 4, slot 0 dropped
    redirect(32'h1c00_0104);
    check_value("pc_o", pc_o, 32'h1c00_0104);
    @(negedge clk);
    next_i = 1'b1;
    #1 check_value("valid_o", valid_o, 2'b10);
    @(negedge clk);
    next_i = 1'b0;
    check_value("pc_o", pc_o, 32'h1c00_0108);

    // Random BTB and counter contents
    for (int i = 0; i < POOL_SIZE; i++) begin
      pool[i] = 32'h4000_0000 | ($urandom & 32'h0000_3ff8);
      for (int s = 0; s < 2; s++) begin
        if ($urandom_range(3, 0) != 0) begin
          slot_pc = pool[i] | (s << 2);
          train_btb(slot_pc, 32'h4000_0000 | ($urandom & 32'h0000_fffc),
                    bpu_pkg::br_type_e'($urandom_range(3, 1)));
          train_pht(slot_pc, bpu_pkg::counter_t'($urandom_range(3, 0)), $urandom_range(1, 0));
        end
      end
    end
    for (int i = 0; i < POOL_SIZE; i++) begin
      redirect(pool[i] | ($urandom_range(1, 0) << 2));
      fetch(1);
    end

    // Counter saturation on one conditional branch
    // Entering at offset 4 makes slot 1 the chosen slot
    train_btb(32'h3000_0044, 32'h3000_0800, bpu_pkg::BR_COND);
    repeat (5) begin
      redirect(32'h3000_0044);
      cnt = pred_counter_o;
      train_pht(32'h3000_0044, cnt, 1'b1);
    end
    redirect(32'h3000_0044);
    check_value("pred_counter_o", pred_counter_o, 2'd3);
    check_value("pred_taken_o", pred_taken_o, 1'b1);
    repeat (5) begin
      redirect(32'h3000_0044);
      cnt = pred_counter_o;
      train_pht(32'h3000_0044, cnt, 1'b0);
    end
    redirect(32'h3000_0044);
    check_value("pred_counter_o", pred_counter_o, 2'd0);
    check_value("pred_taken_o", pred_taken_o, 1'b0);

    // Nested call and return
    train_btb(32'h2000_0100, 32'h2000_0200, bpu_pkg::BR_CALL);
    train_btb(32'h2000_0204, 32'h2000_0318, bpu_pkg::BR_CALL);
    train_btb(32'h2000_0318, 32'h0000_0000, bpu_pkg::BR_RETURN);
    train_btb(32'h2000_0208, 32'h0000_0000, bpu_pkg::BR_RETURN);
    restore(3'd2, 1'b0);
    redirect(32'h2000_0100);
    step_and_check(32'h2000_0200, 3'd3);
    step_and_check(32'h2000_0318, 3'd4);
    step_and_check(32'h2000_0208, 3'd3);
    step_and_check(32'h2000_0104, 3'd2);
    step_and_check(32'h2000_0108, 3'd2);

    // Restore beats a push, then hold with next low
    redirect(32'h2000_0100);
    restore(3'd5, 1'b1);
    check_value("pc_o", pc_o, 32'h2000_0200);
    check_value("ras_ptr_o", ras_ptr_o, 3'd5);
    repeat (10) @(negedge clk);
    check_value("pc_o", pc_o, 32'h2000_0200);
    check_value("ras_ptr_o", ras_ptr_o, 3'd5);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
hw/bpu_pkg.sv
hw/pattern_history_table.sv
hw/branch_target_buffer.sv
hw/return_address_stack.sv
hw/branch_prediction_unit.sv
verif/tb_bpu.sv

/* Bender.yml */
package:
  name: branch_prediction_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bpu_pkg.sv
      - hw/pattern_history_table.sv
      - hw/branch_target_buffer.sv
      - hw/return_address_stack.sv
      - hw/branch_prediction_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_bpu.sv
